// File: source/serial_macros.svh
// --------------------------------------
// serial echo timing and width constants
// clock, baud, character and ring size
// --------------------------------------

`ifndef SERIAL_MACROS_SVH
`define SERIAL_MACROS_SVH

// board clock
`define MAIN_CLK_HZ 27000000

// line rate, 8N1
`define SERIAL_CLK_HZ 115200

// main clocks per serial bit, truncated to 234
`define CLKS_PER_BIT (`MAIN_CLK_HZ / `SERIAL_CLK_HZ)

// data bits per character
`define CHAR_BITS 8

// ring buffer slot index width, 16 entries
`define BUF_ADDR_BITS 4

`endif

// File: source/serial_pkg.sv
// --------------------------------------
// serial echo shared types
// widths, memory request, fsm states
// --------------------------------------

`include "serial_macros.svh"

package serial_pkg;

	// one character on the line
	typedef logic [`CHAR_BITS-1:0] char_t;

	// slot index into the ring
	typedef logic [`BUF_ADDR_BITS-1:0] buf_addr_t;

	// pointer with extra wrap bit for full/empty
	typedef logic [`BUF_ADDR_BITS:0] buf_ptr_t;

	// request from a client to the character memory
	typedef struct packed {
		logic wr;
		buf_addr_t addr;
		char_t data;
	} ram_req_t;

	// receiver fsm
	typedef enum logic [1:0] {rx_st_idle, rx_st_start, rx_st_data, rx_st_stop} rx_state_e;

	// transmitter fsm
	typedef enum logic [1:0] {tx_st_idle, tx_st_start, tx_st_data, tx_st_stop} tx_state_e;

endpackage

// File: source/serial_rx.sv
// --------------------------------------
// serial line receiver, 8N1
// samples once mid-bit from the start edge
// strobes each character with a good stop
// --------------------------------------

`include "serial_macros.svh"

module serial_rx import serial_pkg::*; (
	input logic clk27,
	input logic rst,
	input logic serial_rx,
	output logic rx_valid,
	output char_t rx_char
);

	localparam int CNT_BITS = $clog2(`CLKS_PER_BIT);
	localparam int IDX_BITS = $clog2(`CHAR_BITS);
	localparam logic [CNT_BITS-1:0] HALF_END = CNT_BITS'(`CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_BITS-1:0] BIT_END = CNT_BITS'(`CLKS_PER_BIT - 1);
	localparam logic [IDX_BITS-1:0] LAST_BIT = IDX_BITS'(`CHAR_BITS - 1);

	rx_state_e state;
	logic [CNT_BITS-1:0] cnt;
	logic [IDX_BITS-1:0] bit_idx;
	logic rx_meta, rx_sync, rx_prev;
	char_t shift;

	// --------------------------------------
	// line synchronizer
	// --------------------------------------

	// idle line is high, so reset to one
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= serial_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// --------------------------------------
	// frame fsm
	// --------------------------------------

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= rx_st_idle;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				rx_st_idle: begin
					// falling edge only, a stuck-low line after a bad stop waits here
					if (rx_prev && !rx_sync) begin
						cnt <= '0;
						state <= rx_st_start;
					end
				end
				rx_st_start: begin
					if (cnt == HALF_END) begin
						cnt <= '0;
						bit_idx <= '0;
						// glitch, back to idle
						state <= rx_sync ? rx_st_idle : rx_st_data;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				rx_st_data: begin
					if (cnt == BIT_END) begin
						cnt <= '0;
						if (bit_idx == LAST_BIT)
							state <= rx_st_stop;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				rx_st_stop: begin
					if (cnt == BIT_END) begin
						cnt <= '0;
						// framing error drops the char
						rx_valid <= rx_sync;
						state <= rx_st_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= rx_st_idle;
			endcase
		end
	end

	// data shift, lsb first arrives at the top and moves down
	always_ff @(posedge clk27) begin
		if (state == rx_st_data && cnt == BIT_END)
			shift <= {rx_sync, shift[`CHAR_BITS-1:1]};
	end

	assign rx_char = shift;

	// one strobe per frame
	assert property (@(posedge clk27) disable iff (rst) rx_valid |=> !rx_valid);

endmodule

// File: source/serial_tx.sv
// --------------------------------------
// serial line transmitter, 8N1
// start, 8 data lsb first, stop
// --------------------------------------

`include "serial_macros.svh"

module serial_tx import serial_pkg::*; (
	input logic clk27,
	input logic rst,
	input logic tx_start,
	input char_t tx_char,
	output logic tx_busy,
	output logic serial_tx
);

	localparam int CNT_BITS = $clog2(`CLKS_PER_BIT);
	localparam int IDX_BITS = $clog2(`CHAR_BITS);
	localparam logic [CNT_BITS-1:0] BIT_END = CNT_BITS'(`CLKS_PER_BIT - 1);
	localparam logic [IDX_BITS-1:0] LAST_BIT = IDX_BITS'(`CHAR_BITS - 1);

	tx_state_e state;
	logic [CNT_BITS-1:0] cnt;
	logic [IDX_BITS-1:0] bit_idx;
	logic bit_end, load, shift_en;
	char_t shift;

	assign bit_end = (cnt == BIT_END);
	assign load = (state == tx_st_idle) && tx_start;
	// next data bit leaves at the end of start and of each data bit
	assign shift_en = bit_end && (state == tx_st_start || state == tx_st_data);

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= tx_st_idle;
			cnt <= '0;
			bit_idx <= '0;
			serial_tx <= 1'b1;
		end else begin
			// bit timer, free while idle
			cnt <= (bit_end || state == tx_st_idle) ? '0 : cnt + 1'b1;
			case (state)
				tx_st_idle: begin
					if (tx_start) begin
						serial_tx <= 1'b0;
						state <= tx_st_start;
					end
				end
				tx_st_start: begin
					if (bit_end) begin
						serial_tx <= shift[0];
						bit_idx <= '0;
						state <= tx_st_data;
					end
				end
				tx_st_data: begin
					if (bit_end) begin
						if (bit_idx == LAST_BIT) begin
							serial_tx <= 1'b1;
							state <= tx_st_stop;
						end else begin
							serial_tx <= shift[0];
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				tx_st_stop: begin
					// busy drops as the stop bit ends
					if (bit_end)
						state <= tx_st_idle;
				end
				default: state <= tx_st_idle;
			endcase
		end
	end

	// character shift register
	always_ff @(posedge clk27) begin
		if (load)
			shift <= tx_char;
		else if (shift_en)
			shift <= shift >> 1;
	end

	assign tx_busy = (state != tx_st_idle);

	// fetch side must wait for the line
	assert property (@(posedge clk27) disable iff (rst) tx_start |-> !tx_busy);

endmodule

// File: source/rx_store.sv
// --------------------------------------
// receive side memory client
// writes each char at the write pointer
// sticky overflow when the ring is full
// --------------------------------------

`include "serial_macros.svh"

module rx_store import serial_pkg::*; (
	input logic clk27,
	input logic rst,
	input logic rx_valid,
	input char_t rx_char,
	input buf_ptr_t rd_ptr,
	output buf_ptr_t wr_ptr,
	output logic req,
	input logic gnt,
	output ram_req_t req_data,
	output logic overflow
);

	localparam buf_ptr_t DEPTH = buf_ptr_t'(1 << `BUF_ADDR_BITS);

	buf_ptr_t fill;
	logic full;
	char_t char_q;

	// wrap bit makes the difference the fill level
	assign fill = wr_ptr - rd_ptr;
	assign full = (fill == DEPTH);

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			req <= 1'b0;
			overflow <= 1'b0;
		end else begin
			if (gnt) begin
				req <= 1'b0;
				wr_ptr <= wr_ptr + 1'b1;
			end else if (rx_valid && !full) begin
				req <= 1'b1;
			end
			// dropped char, held until reset
			if (rx_valid && full)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk27) begin
		if (rx_valid)
			char_q <= rx_char;
	end

	assign req_data = '{wr: 1'b1, addr: wr_ptr[`BUF_ADDR_BITS-1:0], data: char_q};

	// read side never passes write side, write side never laps
	assert property (@(posedge clk27) disable iff (rst) fill <= DEPTH);

endmodule

// File: source/tx_fetch.sv
// --------------------------------------
// transmit side memory client
// reads the next char and starts the line
// --------------------------------------

`include "serial_macros.svh"

module tx_fetch import serial_pkg::*; (
	input logic clk27,
	input logic rst,
	input buf_ptr_t wr_ptr,
	output buf_ptr_t rd_ptr,
	input logic tx_pause,
	input logic tx_busy,
	output logic req,
	input logic gnt,
	output ram_req_t req_data,
	input char_t rd_data,
	output logic tx_start,
	output char_t tx_char
);

	logic empty;
	logic pending;

	assign empty = (wr_ptr == rd_ptr);

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			req <= 1'b0;
			pending <= 1'b0;
		end else begin
			// read data is on rd_data the cycle after gnt
			pending <= gnt;
			if (gnt)
				req <= 1'b0;
			else if (!req && !pending && !empty && !tx_busy && !tx_pause)
				req <= 1'b1;
			// slot consumed as the transmitter takes it
			if (pending)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// read request, data field unused
	assign req_data = '{wr: 1'b0, addr: rd_ptr[`BUF_ADDR_BITS-1:0], data: '0};

	// start strobe lines up with the registered read
	assign tx_start = pending;
	assign tx_char = rd_data;

endmodule

// File: source/char_ram_arbiter.sv
// --------------------------------------
// round-robin arbiter, two clients
// steers the winner onto the char memory
// --------------------------------------

module char_ram_arbiter import serial_pkg::*; (
	input logic clk27,
	input logic rst,
	input logic rx_req,
	input ram_req_t rx_req_data,
	output logic rx_gnt,
	input logic tx_req,
	input ram_req_t tx_req_data,
	output logic tx_gnt,
	output ram_req_t ram_req,
	output logic ram_en
);

	// set when receive side had the last grant
	logic last_rx;
	logic pick_tx;

	// on a tie the side not served last wins
	assign pick_tx = tx_req && (!rx_req || last_rx);
	assign tx_gnt = pick_tx;
	assign rx_gnt = rx_req && !pick_tx;

	assign ram_en = rx_gnt || tx_gnt;
	assign ram_req = pick_tx ? tx_req_data : rx_req_data;

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			last_rx <= 1'b0;
		end else if (rx_gnt) begin
			last_rx <= 1'b1;
		end else if (tx_gnt) begin
			last_rx <= 1'b0;
		end
	end

	// single-port memory, one access per cycle
	assert property (@(posedge clk27) disable iff (rst) !(rx_gnt && tx_gnt));

endmodule

// File: source/char_ram.sv
// --------------------------------------
// 16 x 8 single-port char memory
// sync write, registered read
// --------------------------------------

`include "serial_macros.svh"

module char_ram import serial_pkg::*; (
	input logic clk27,
	input logic ram_en,
	input ram_req_t ram_req,
	output char_t rd_data
);

	localparam int DEPTH = 1 << `BUF_ADDR_BITS;

	char_t mem [DEPTH];

	// rd_data holds across writes and idle cycles
	always_ff @(posedge clk27) begin
		if (ram_en) begin
			if (ram_req.wr)
				mem[ram_req.addr] <= ram_req.data;
			else
				rd_data <= mem[ram_req.addr];
		end
	end

endmodule

// File: source/serial_echo.sv
// --------------------------------------
// serial echo top level
// rx line into ring buffer, back out on tx
// pause input, sticky overflow output
// --------------------------------------

module serial_echo import serial_pkg::*; (
	input logic clk27,
	input logic rst,
	input logic serial_rx,
	input logic tx_pause,
	output logic serial_tx,
	output logic overflow
);

	// receiver to store
	logic rx_valid;
	char_t rx_char;

	// pointer exchange
	buf_ptr_t wr_ptr, rd_ptr;

	// memory clients
	logic rx_req, rx_gnt, tx_req, tx_gnt;
	ram_req_t rx_req_data, tx_req_data;

	// memory port
	ram_req_t ram_req;
	logic ram_en;
	char_t rd_data;

	// fetch to transmitter
	logic tx_start, tx_busy;
	char_t tx_char;

	// --------------------------------------
	// receive path
	// --------------------------------------

	serial_rx u_rx (.clk27(clk27), .rst(rst), .serial_rx(serial_rx),
		.rx_valid(rx_valid), .rx_char(rx_char));

	rx_store u_store (.clk27(clk27), .rst(rst), .rx_valid(rx_valid), .rx_char(rx_char),
		.rd_ptr(rd_ptr), .wr_ptr(wr_ptr), .req(rx_req), .gnt(rx_gnt),
		.req_data(rx_req_data), .overflow(overflow));

	// --------------------------------------
	// shared memory
	// --------------------------------------

	char_ram_arbiter u_arb (.clk27(clk27), .rst(rst),
		.rx_req(rx_req), .rx_req_data(rx_req_data), .rx_gnt(rx_gnt),
		.tx_req(tx_req), .tx_req_data(tx_req_data), .tx_gnt(tx_gnt),
		.ram_req(ram_req), .ram_en(ram_en));

	char_ram u_ram (.clk27(clk27), .ram_en(ram_en), .ram_req(ram_req), .rd_data(rd_data));

	// --------------------------------------
	// transmit path
	// --------------------------------------

	tx_fetch u_fetch (.clk27(clk27), .rst(rst), .wr_ptr(wr_ptr), .rd_ptr(rd_ptr),
		.tx_pause(tx_pause), .tx_busy(tx_busy), .req(tx_req), .gnt(tx_gnt),
		.req_data(tx_req_data), .rd_data(rd_data), .tx_start(tx_start), .tx_char(tx_char));

	serial_tx u_tx (.clk27(clk27), .rst(rst), .tx_start(tx_start), .tx_char(tx_char),
		.tx_busy(tx_busy), .serial_tx(serial_tx));

endmodule

// File: tb/tb_serial_echo.sv
// --------------------------------------
// testbench for the serial echo unit
// drives 8N1 frames, decodes the echo and
// compares against a reference model
// --------------------------------------

`include "serial_macros.svh"

module tb_serial_echo import serial_pkg::*; ();

	localparam int FRAME_CYCLES = 10 * `CLKS_PER_BIT;
	localparam int DEPTH = 1 << `BUF_ADDR_BITS;
	// about 85 frames with settle time, well inside this
	localparam int TIMEOUT_CYCLES = 400000;

	logic clk27, rst, serial_rx, tx_pause;
	logic serial_tx, overflow;

	logic [31:0] lfsr;
	int cycle_count;
	bit ovf_expected;

	// sent characters with their stop flags, and decoded echoes
	char_t sent_chars[$];
	bit sent_good[$];
	char_t echoed[$];

	serial_echo uut (.clk27(clk27), .rst(rst), .serial_rx(serial_rx), .tx_pause(tx_pause),
		.serial_tx(serial_tx), .overflow(overflow));

	initial begin
		clk27 = 1'b0;
		forever #4 clk27 = ~clk27;
	end

	// --------------------------------------
	// helpers
	// --------------------------------------

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per data bit
	task automatic next_random_char(output char_t c);
		int i;
		for (i = 0; i < `CHAR_BITS; i++) begin
			lfsr = lfsr_next(lfsr);
			c[i] = lfsr[0];
		end
	endtask

	// called on a falling edge, leaves on one
	task automatic drive_bit(input logic b);
		serial_rx = b;
		repeat (`CLKS_PER_BIT) @(negedge clk27);
	endtask

	task automatic send_char(input char_t c, input bit good_stop);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < `CHAR_BITS; i++)
			drive_bit(c[i]);
		drive_bit(good_stop);
		// idle bit so the next start edge is seen
		if (!good_stop)
			drive_bit(1'b1);
		sent_chars.push_back(c);
		sent_good.push_back(good_stop);
	endtask

	// reference model
	// depth 0 means the line drains, otherwise the ring holds depth entries
	function automatic void model_echo(input char_t chars[$], input bit good[$],
		input int depth, output char_t exp[$], output bit ovf);
		int held;
		int i;
		held = 0;
		ovf = 1'b0;
		exp.delete();
		for (i = 0; i < chars.size(); i++) begin
			if (good[i]) begin
				if (depth != 0 && held >= depth) begin
					ovf = 1'b1;
				end else begin
					exp.push_back(chars[i]);
					held++;
				end
			end
		end
	endfunction

	// --------------------------------------
	// echo line monitor
	// --------------------------------------

	initial begin
		char_t c;
		int i;
		@(negedge rst);
		forever begin
			// outputs change on posedge, sample on negedge
			do @(negedge clk27); while (serial_tx !== 1'b0);
			repeat (`CLKS_PER_BIT / 2) @(negedge clk27);
			if (serial_tx !== 1'b0)
				abort_run("echo start bit did not stay low");
			for (i = 0; i < `CHAR_BITS; i++) begin
				repeat (`CLKS_PER_BIT) @(negedge clk27);
				c[i] = serial_tx;
			end
			repeat (`CLKS_PER_BIT) @(negedge clk27);
			if (serial_tx !== 1'b1)
				abort_run("echo frame has a low stop bit");
			echoed.push_back(c);
		end
	end

	// run limit
	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk27);
			cycle_count++;
			if (cycle_count >= TIMEOUT_CYCLES)
				abort_run("simulation ran past the cycle limit without finishing");
		end
	end

	// --------------------------------------
	// one test: send, compare echo and overflow
	// --------------------------------------

	task automatic run_test(input string name, input int count, input int bad_idx,
		input bit paused);
		char_t c;
		char_t exp[$];
		bit ovf;
		int waited;
		int limit;
		int i;
		sent_chars.delete();
		sent_good.delete();
		echoed.delete();
		if (paused)
			tx_pause = 1'b1;
		for (i = 0; i < count; i++) begin
			next_random_char(c);
			send_char(c, i != bad_idx);
		end
		if (paused) begin
			// nothing may leave while held back
			repeat (2 * FRAME_CYCLES) @(negedge clk27);
			check({name, " frames while paused"}, 0, echoed.size());
			tx_pause = 1'b0;
		end
		model_echo(sent_chars, sent_good, paused ? DEPTH : 0, exp, ovf);
		ovf_expected = ovf_expected | ovf;
		limit = (exp.size() + 2) * FRAME_CYCLES;
		waited = 0;
		while (echoed.size() < exp.size()) begin
			if (waited >= limit) begin
				abort_run({name, ": echo frames did not arrive in time"});
			end else begin
				@(negedge clk27);
				waited++;
			end
		end
		// catch any extra frame
		repeat (2 * FRAME_CYCLES) @(negedge clk27);
		check({name, " echo count"}, exp.size(), echoed.size());
		for (i = 0; i < exp.size(); i++)
			check($sformatf("%s char %0d", name, i), 32'(exp[i]), 32'(echoed[i]));
		check({name, " overflow"}, 32'(ovf_expected), 32'(overflow));
	endtask

	// --------------------------------------
	// main sequence
	// --------------------------------------

	initial begin
		rst = 1'b1;
		serial_rx = 1'b1;
		tx_pause = 1'b0;
		lfsr = 32'h0fc8_3cbb;
		ovf_expected = 1'b0;
		repeat (16) @(posedge clk27);
		@(negedge clk27);
		rst = 1'b0;
		repeat (4) @(negedge clk27);

		check("reset serial_tx", 1, 32'(serial_tx));
		check("reset overflow", 0, 32'(overflow));
		run_test("single", 1, -1, 1'b0);
		run_test("back_to_back", 8, -1, 1'b0);
		run_test("bad_stop", 3, 1, 1'b0);
		run_test("pause_ten", 10, -1, 1'b1);
		run_test("pause_overflow", 18, -1, 1'b1);
		// flag must hold with traffic flowing again
		run_test("overflow_sticky", 1, -1, 1'b0);

		$display("All tests passed");
		$finish;
	end

endmodule

// File: files.f
+incdir+source
source/serial_pkg.sv
source/serial_rx.sv
source/serial_tx.sv
source/rx_store.sv
source/tx_fetch.sv
source/char_ram_arbiter.sv
source/char_ram.sv
source/serial_echo.sv
tb/tb_serial_echo.sv

// File: run.sh
#!/bin/sh
# build and run the serial echo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_serial_echo \
	-Mdir obj_dir -o sim_serial_echo
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_serial_echo > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "All tests passed" sim.log; then
	if [ $sim_status -ne 0 ]; then
		echo "simulator returned status $sim_status"
		exit 1
	fi
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
